// File: run.sh
#!/bin/sh
# build and run the expu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module expu_tb -o expu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/expu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// File: src.f
src/expu_pkg.sv
src/expu_stream_if.sv
src/expu_dispatch.sv
src/expu_lane.sv
src/expu_collect.sv
src/expu_top.sv
tests/expu_properties.sv
tests/expu_tb.sv

// File: src/expu_collect.sv
`timescale 1ns/100ps

module expu_collect #(
    parameter int NUM_LANES = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    expu_stream_if.sink                     result,
    input  logic                            out_credit,
    output logic                            out_valid,
    output expu_pkg::bf16_t [NUM_LANES-1:0] out_data,
    output logic [NUM_LANES-1:0]            out_mask,
    output logic                            out_last,
    output logic                            free
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;

    expu_pkg::bf16_t [NUM_LANES-1:0] data_mem [OUT_DEPTH];
    logic [NUM_LANES-1:0]            mask_mem [OUT_DEPTH];
    logic                            last_mem [OUT_DEPTH];

    expu_pkg::bf16_t [NUM_LANES-1:0] wr_data;
    logic [PTR_W-1:0]                wr_ptr;
    logic [PTR_W-1:0]                rd_ptr;
    expu_pkg::credit_cnt_t           count;
    expu_pkg::credit_cnt_t           out_cnt;      // credits granted by the consumer
    logic                            send;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_data[i] = result.mask[i] ? result.data[i] : '0;   // padding reads as zero
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) begin
            data_mem[wr_ptr] <= wr_data;
            mask_mem[wr_ptr] <= result.mask;
            last_mem[wr_ptr] <= result.last;
        end
    end

    assign send = (count != '0) && (out_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_cnt <= '0;
        end else begin
            if (result.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + expu_pkg::credit_cnt_t'(result.valid)
                             - expu_pkg::credit_cnt_t'(send);
            out_cnt <= out_cnt + expu_pkg::credit_cnt_t'(out_credit)
                               - expu_pkg::credit_cnt_t'(send);
        end
    end

    // outputs stay quiet between beats
    assign out_valid = send;
    assign out_data  = send ? data_mem[rd_ptr] : '0;
    assign out_mask  = send ? mask_mem[rd_ptr] : '0;
    assign out_last  = send ? last_mem[rd_ptr] : 1'b0;
    assign free      = send;                 // slot returned to the dispatcher

endmodule

// File: src/expu_dispatch.sv
`timescale 1ns/100ps

module expu_dispatch #(
    parameter int NUM_LANES = 4,
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  expu_pkg::bf16_t [NUM_LANES-1:0] in_data,
    input  logic [NUM_LANES-1:0]            in_mask,
    input  logic                            in_last,
    input  logic                            free,
    output logic                            in_credit,
    expu_stream_if.source                   issue
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

    expu_pkg::bf16_t [NUM_LANES-1:0] data_mem [IN_DEPTH];
    logic [NUM_LANES-1:0]            mask_mem [IN_DEPTH];
    logic                            last_mem [IN_DEPTH];

    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    expu_pkg::credit_cnt_t count;
    expu_pkg::credit_cnt_t credit;      // free slots in the collector
    logic                  pop;

    assign pop = (count != '0) && (credit != '0);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_mem[wr_ptr] <= in_data;
            mask_mem[wr_ptr] <= in_mask;
            last_mem[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= expu_pkg::credit_cnt_t'(OUT_DEPTH);
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + expu_pkg::credit_cnt_t'(in_valid)
                            - expu_pkg::credit_cnt_t'(pop);
            credit <= credit + expu_pkg::credit_cnt_t'(free)
                             - expu_pkg::credit_cnt_t'(pop);
        end
    end

    assign issue.valid = pop;
    assign issue.data  = data_mem[rd_ptr];
    assign issue.mask  = mask_mem[rd_ptr];
    assign issue.last  = last_mem[rd_ptr];
    assign in_credit   = pop;                 // slot freed as the head leaves

endmodule

// File: src/expu_lane.sv
`timescale 1ns/100ps

module expu_lane #(
    parameter int A_FRACTION      = 14,
    parameter bit ENABLE_ROUNDING = 1'b1,
    parameter int TAG_BITS        = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  expu_pkg::bf16_t     op,
    input  logic [TAG_BITS-1:0] op_tag,
    output logic                res_valid,
    output expu_pkg::bf16_t     res,
    output logic [TAG_BITS-1:0] res_tag
);

    localparam int  EXP_BITS   = expu_pkg::EXP_BITS;
    localparam int  MAN_BITS   = expu_pkg::MAN_BITS;
    localparam int  A_INT_BITS = 1;                      // 1/ln2 lies in [1,2)
    localparam int  A_WIDTH    = A_INT_BITS + A_FRACTION;
    localparam int  PROD_TOP   = MAN_BITS + A_WIDTH;     // Q2.(MAN_BITS+A_FRACTION)
    localparam real A_REAL     = 1.0 / $ln(2.0);

    localparam logic [A_WIDTH-1:0] A = A_WIDTH'($rtoi(A_REAL * (2.0 ** A_FRACTION)));

    logic                   sign_d;
    expu_pkg::exp_field_t   exp_d;
    logic [MAN_BITS:0]      man_d;                       // hidden one restored
    logic [PROD_TOP:0]      prod_d;
    logic                   ovf_d;

    logic                   valid_q;
    logic                   sign_q;
    expu_pkg::exp_field_t   exp_q;
    logic [PROD_TOP:0]      prod_q;
    logic                   ovf_q;
    logic [TAG_BITS-1:0]    tag_q;

    expu_pkg::exp_field_t             shift_amt;
    logic [EXP_BITS+MAN_BITS:0]       shifted;
    logic [EXP_BITS+MAN_BITS-1:0]     rounded;
    logic [EXP_BITS+MAN_BITS-1:0]     signed_val;
    expu_pkg::exp_field_t             new_exp;
    expu_pkg::man_field_t             new_man;

    assign sign_d = op[expu_pkg::BF16_WIDTH-1];
    assign exp_d  = op[MAN_BITS +: EXP_BITS];
    assign man_d  = {1'b1, op[MAN_BITS-1:0]};
    assign prod_d = man_d * A;

    assign ovf_d = (exp_d > expu_pkg::MAX_EXP) ||
                   ((exp_d == expu_pkg::MAX_EXP) &&
                    (prod_d[PROD_TOP] ||
                     (sign_d && (&prod_d[PROD_TOP-1 -: EXP_BITS]))));

    always_ff @(posedge clk) begin
        sign_q <= sign_d;
        exp_q  <= exp_d;
        prod_q <= prod_d;
        ovf_q  <= ovf_d;
        tag_q  <= op_tag;
    end

    assign shift_amt  = expu_pkg::exp_field_t'(expu_pkg::MAX_EXP) - exp_q;
    assign shifted    = prod_q[PROD_TOP : A_FRACTION - MAN_BITS] >> shift_amt;
    assign rounded    = shifted[EXP_BITS+MAN_BITS:1] + (ENABLE_ROUNDING ? shifted[0] : 1'b0);
    assign signed_val = sign_q ? -rounded : rounded;

    always_comb begin
        if (!ovf_q) begin
            new_exp = signed_val[MAN_BITS +: EXP_BITS]
                    + expu_pkg::exp_field_t'(expu_pkg::BF16_BIAS);
            new_man = signed_val[MAN_BITS-1:0];
        end else begin
            new_exp = sign_q ? '0 : '1;                  // zero or infinity
            new_man = '0;
        end
    end

    always_ff @(posedge clk) begin
        res     <= {1'b0, new_exp, new_man};
        res_tag <= tag_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_q   <= op_valid;
            res_valid <= valid_q;
        end
    end

endmodule

// File: src/expu_pkg.sv
package expu_pkg;

    localparam int BF16_WIDTH  = 16;
    localparam int EXP_BITS    = 8;
    localparam int MAN_BITS    = 7;
    localparam int BF16_BIAS   = 127;

    // one integer bit for 1/ln2 and one for the hidden mantissa bit
    localparam int MAX_EXP     = BF16_BIAS + EXP_BITS - 2;

    localparam int CREDIT_BITS = 4;

    typedef logic [BF16_WIDTH-1:0]  bf16_t;
    typedef logic [EXP_BITS-1:0]    exp_field_t;
    typedef logic [MAN_BITS-1:0]    man_field_t;
    typedef logic [CREDIT_BITS-1:0] credit_cnt_t;   // covers depths up to 15

endpackage

// File: src/expu_stream_if.sv
`timescale 1ns/100ps

interface expu_stream_if #(
    parameter int NUM_LANES = 4
);

    logic                            valid;
    expu_pkg::bf16_t [NUM_LANES-1:0] data;
    logic [NUM_LANES-1:0]            mask;     // set for real elements
    logic                            last;     // final beat of a row

    // space is guaranteed by credits so there is no ready
    modport source (
        output valid,
        output data,
        output mask,
        output last
    );

    modport sink (
        input valid,
        input data,
        input mask,
        input last
    );

endinterface

// File: src/expu_top.sv
`timescale 1ns/100ps

module expu_top #(
    parameter int NUM_LANES       = 4,
    parameter int A_FRACTION      = 14,
    parameter bit ENABLE_ROUNDING = 1'b1,
    parameter int IN_DEPTH        = 4,
    parameter int OUT_DEPTH       = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  expu_pkg::bf16_t [NUM_LANES-1:0] in_data,
    input  logic [NUM_LANES-1:0]            in_mask,
    input  logic                            in_last,
    output logic                            in_credit,
    output logic                            out_valid,
    output expu_pkg::bf16_t [NUM_LANES-1:0] out_data,
    output logic [NUM_LANES-1:0]            out_mask,
    output logic                            out_last,
    input  logic                            out_credit
);

    expu_stream_if #(.NUM_LANES(NUM_LANES)) issue ();
    expu_stream_if #(.NUM_LANES(NUM_LANES)) result ();

    logic free;

    expu_dispatch #(
        .NUM_LANES (NUM_LANES),
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mask   (in_mask),
        .in_last   (in_last),
        .free      (free),
        .in_credit (in_credit),
        .issue     (issue)
    );

    // lane 0 also carries the beat valid and last flag through the pipe
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        if (i == 0) begin : g_head
            expu_lane #(
                .A_FRACTION      (A_FRACTION),
                .ENABLE_ROUNDING (ENABLE_ROUNDING),
                .TAG_BITS        (2)
            ) u_lane (
                .clk       (clk),
                .rst_n     (rst_n),
                .op_valid  (issue.valid),
                .op        (issue.data[i]),
                .op_tag    ({issue.last, issue.mask[i]}),
                .res_valid (result.valid),
                .res       (result.data[i]),
                .res_tag   ({result.last, result.mask[i]})
            );
        end else begin : g_body
            expu_lane #(
                .A_FRACTION      (A_FRACTION),
                .ENABLE_ROUNDING (ENABLE_ROUNDING),
                .TAG_BITS        (1)
            ) u_lane (
                .clk       (clk),
                .rst_n     (rst_n),
                .op_valid  (issue.valid),
                .op        (issue.data[i]),
                .op_tag    (issue.mask[i]),
                .res_valid (),                  // same timing as lane 0
                .res       (result.data[i]),
                .res_tag   (result.mask[i])
            );
        end
    end

    expu_collect #(
        .NUM_LANES (NUM_LANES),
        .OUT_DEPTH (OUT_DEPTH)
    ) u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .result     (result),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_mask   (out_mask),
        .out_last   (out_last),
        .free       (free)
    );

endmodule

// File: tests/expu_properties.sv
`timescale 1ns/100ps

module expu_properties #(
    parameter int NUM_LANES = 4
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            in_valid,
    input logic                            in_credit,
    input logic                            out_valid,
    input expu_pkg::bf16_t [NUM_LANES-1:0] out_data,
    input logic [NUM_LANES-1:0]            out_mask,
    input logic                            out_last,
    input logic                            out_credit
);

    int accepted;
    int returned;
    int avail;                                     // consumer credits not yet spent

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accepted <= 0;
            returned <= 0;
            avail    <= 0;
        end else begin
            accepted <= accepted + int'(in_valid);
            returned <= returned + int'(in_credit);
            avail    <= avail + int'(out_credit) - int'(out_valid);
        end
    end

    a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> avail > 0)
        else $error("out_valid raised with no consumer credit left");

    a_credit_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit |-> returned < accepted)
        else $error("in_credit returned for a beat that was never accepted");

    a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({in_credit, out_valid, out_data, out_mask, out_last}))
        else $error("unknown value on a DUT output");

endmodule

bind expu_top expu_properties #(.NUM_LANES(NUM_LANES)) u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_mask   (out_mask),
    .out_last   (out_last),
    .out_credit (out_credit)
);

// File: tests/expu_tb.sv
`timescale 1ns/100ps

module expu_tb;

    localparam int NUM_LANES    = 4;
    localparam int IN_DEPTH     = 4;
    localparam int OUT_DEPTH    = 4;
    localparam int NUM_BEATS    = 400;
    localparam int RUN_LIMIT    = 20000;
    localparam int STARVE_LIMIT = 400;
    localparam int DRAIN_LIMIT  = 200;

    typedef expu_pkg::bf16_t [NUM_LANES-1:0] vec_t;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    vec_t                 in_data;
    logic [NUM_LANES-1:0] in_mask;
    logic                 in_last;
    logic                 in_credit;
    logic                 out_valid;
    vec_t                 out_data;
    logic [NUM_LANES-1:0] out_mask;
    logic                 out_last;
    logic                 out_credit;

    vec_t                 data_q[$];
    logic [NUM_LANES-1:0] mask_q[$];
    logic                 last_q[$];

    logic [31:0] rng_state = 32'd45;
    int credits;                                   // producer credits held
    int sent;
    int returned;
    int received;
    int granted;
    int data_errors;
    int mask_errors;
    int last_errors;
    int other_errors;

    expu_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_mask    (in_mask),
        .in_last    (in_last),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_mask   (out_mask),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Schraudolph e^x with A = 1/ln2 * 2^14 and rounding on
    function automatic expu_pkg::bf16_t exp_ref(input expu_pkg::bf16_t x);
        logic        sign;
        logic [7:0]  e;
        logic [22:0] prod;
        logic [15:0] kept;
        logic [14:0] mag;
        logic [14:0] val;
        logic [7:0]  new_e;
        sign = x[15];
        e    = x[14:7];
        prod = 23'({1'b1, x[6:0]}) * 23'd23637;
        if (e > 8'd133 || (e == 8'd133 && (prod[22] || (sign && &prod[21:14])))) begin
            return sign ? 16'h0000 : 16'h7f80;
        end
        kept  = prod[22:7] >> (8'd133 - e);
        mag   = kept[15:1] + 15'(kept[0]);
        val   = sign ? -mag : mag;
        new_e = val[14:7] + 8'd127;
        return {1'b0, new_e, val[6:0]};
    endfunction

    function automatic expu_pkg::bf16_t rand_operand();
        logic [31:0] r;
        logic [31:0] s;
        logic [7:0]  e;
        logic [6:0]  man;
        r   = next_rand();
        s   = next_rand();
        man = s[6:0];
        case (r[3:0])
            4'd0:       e = 8'd133;                // saturation boundary
            4'd1: begin
                e   = 8'd133;
                man = 7'd48 + 7'(s[8:7]);          // product top bits near all ones
            end
            4'd2:       e = 8'd134 + 8'(r[9:4]);
            4'd3:       e = r[11:4];
            default:    e = 8'd110 + 8'(r[31:8] % 31);
        endcase
        return {s[31], e, man};
    endfunction

    task automatic check_data(input expu_pkg::bf16_t got, input expu_pkg::bf16_t want,
                              input int lane);
        if (got !== want) begin
            data_errors++;
            $display("mismatch at %0t: lane %0d data %h, expected %h", $time, lane, got, want);
        end
    endtask

    task automatic check_mask(input logic [NUM_LANES-1:0] got, input logic [NUM_LANES-1:0] want);
        if (got !== want) begin
            mask_errors++;
            $display("mismatch at %0t: mask %b, expected %b", $time, got, want);
        end
    endtask

    task automatic check_last(input logic got, input logic want);
        if (got !== want) begin
            last_errors++;
            $display("mismatch at %0t: last %b, expected %b", $time, got, want);
        end
    endtask

    // outputs settle mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                credits++;
                returned++;
            end
            if (out_valid) begin
                received++;
                if (received > granted) begin
                    other_errors++;
                    $display("output beat at %0t was sent without a granted credit", $time);
                end
                if (data_q.size() == 0) begin
                    other_errors++;
                    $display("output beat at %0t arrived with nothing pending", $time);
                end else begin
                    for (int i = 0; i < NUM_LANES; i++) begin
                        check_data(out_data[i], data_q[0][i], i);
                    end
                    check_mask(out_mask, mask_q[0]);
                    check_last(out_last, last_q[0]);
                    void'(data_q.pop_front());
                    void'(mask_q.pop_front());
                    void'(last_q.pop_front());
                end
            end
        end
    end

    initial begin
        logic [31:0]          r;
        vec_t                 v;
        vec_t                 want;
        logic [NUM_LANES-1:0] m;
        int                   gap;
        int                   stall;
        int                   starve;
        int                   cycles;
        bit                   aborted;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_mask    = '0;
        in_last    = 1'b0;
        out_credit = 1'b0;
        credits    = IN_DEPTH;
        gap        = 0;
        stall      = 0;
        starve     = 0;
        cycles     = 0;
        aborted    = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        while (!aborted && (sent < NUM_BEATS || data_q.size() != 0)) begin
            @(posedge clk);
            #1;
            in_valid   = 1'b0;
            out_credit = 1'b0;
            r = next_rand();
            if (stall == 0 && r[7:0] < 8'd4) begin
                stall = 40 + int'(r[13:8]);        // consumer goes quiet for a while
            end
            if (stall != 0) begin
                stall--;
            end else if (granted - received < OUT_DEPTH && r[15:14] != 2'b00) begin
                out_credit = 1'b1;
                granted++;
            end
            if (sent < NUM_BEATS) begin
                if (gap != 0) begin
                    gap--;
                end else if (credits > 0) begin
                    m = r[23] ? '1 : NUM_LANES'(r[27:24]);
                    for (int i = 0; i < NUM_LANES; i++) begin
                        v[i]    = rand_operand();
                        want[i] = m[i] ? exp_ref(v[i]) : '0;
                    end
                    in_data  = v;
                    in_mask  = m;
                    in_last  = (r[29:28] == 2'b00);
                    in_valid = 1'b1;
                    data_q.push_back(want);
                    mask_q.push_back(m);
                    last_q.push_back(in_last);
                    credits--;
                    sent++;
                    starve = 0;
                    gap = (r[19:17] == 3'd0) ? int'(r[22:20]) : 0;
                end else begin
                    starve++;
                    if (starve > STARVE_LIMIT) begin
                        other_errors++;
                        $display("producer got no input credit for %0d cycles", starve);
                        aborted = 1'b1;
                    end
                end
            end
            cycles++;
            if (cycles > RUN_LIMIT) begin
                other_errors++;
                $display("run did not finish within %0d cycles", RUN_LIMIT);
                aborted = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        out_credit = 1'b0;

        cycles = 0;
        while (!aborted && returned != sent) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                other_errors++;
                $display("input credits were not all returned, %0d of %0d", returned, sent);
                aborted = 1'b1;
            end
        end
        if (!aborted && received != NUM_BEATS) begin
            other_errors++;
            $display("received %0d output beats, expected %0d", received, NUM_BEATS);
        end

        $display("errors: data %0d, mask %0d, last %0d, other %0d",
                 data_errors, mask_errors, last_errors, other_errors);
        if (data_errors + mask_errors + last_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
